/* logic/cmac_axis_pkg.sv */
package cmac_axis_pkg;

    // up to 7 bad frames per cycle from the MAC
    localparam int BAD_FCS_WIDTH = 3;

    // handshake levels of one stream beat
    // tdata/tkeep/tuser are not observed by any statistic
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } axis_beat_t;

    // beat transferred this cycle
    function automatic logic beat_accepted(axis_beat_t beat);
        return beat.valid && beat.ready;
    endfunction

    // source offered data but sink held off
    function automatic logic beat_lost(axis_beat_t beat);
        return beat.valid && !beat.ready;
    endfunction

    // accepted beat closing a packet
    function automatic logic beat_ends_pkt(axis_beat_t beat);
        return beat_accepted(beat) && beat.last;
    endfunction

endpackage

/* logic/cmac_stat_pkg.sv */
package cmac_stat_pkg;

    localparam int STAT_WIDTH_DEFAULT = 32;

    // one report word; narrower counters are zero extended into it
    typedef logic [STAT_WIDTH_DEFAULT-1:0] stat_cnt_t;

    // per-stream packet statistics
    typedef struct packed {
        stat_cnt_t pkt_count;     // completed packets
        stat_cnt_t beat_count;    // accepted beats
        stat_cnt_t max_pkt_size;  // in beats
        logic      idle;          // no packet in progress
    } pkt_stats_t;

    // receive side report
    typedef struct packed {
        pkt_stats_t pkt;
        stat_cnt_t  lost_beat_count;
        stat_cnt_t  bad_fcs_count;
    } rx_stats_t;

    // send side report
    typedef struct packed {
        pkt_stats_t pkt;
        stat_cnt_t  ovf_count;
        stat_cnt_t  unf_count;
    } tx_stats_t;

endpackage

/* logic/cmac_pkt_tracker.sv */
`timescale 1ns/1ps

module cmac_pkt_tracker
    import cmac_axis_pkg::*, cmac_stat_pkg::*;
#(
    parameter int STAT_WIDTH = STAT_WIDTH_DEFAULT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  axis_beat_t beat,
    output pkt_stats_t stats
);

    logic [STAT_WIDTH-1:0] cur_beats;   // beats of the packet in progress
    logic [STAT_WIDTH-1:0] pkt_size;
    logic [STAT_WIDTH-1:0] pkt_count;
    logic [STAT_WIDTH-1:0] beat_count;
    logic [STAT_WIDTH-1:0] max_pkt;
    logic                  idle;
    logic                  accepted;
    logic                  pkt_done;

    assign accepted = beat_accepted(beat);
    assign pkt_done = beat_ends_pkt(beat);
    assign pkt_size = cur_beats + STAT_WIDTH'(1); // counts the current beat too

    // running size of the open packet and idle flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_beats <= '0;
            idle      <= 1'b1;
        end else if (pkt_done) begin
            cur_beats <= '0;
            idle      <= 1'b1;
        end else if (accepted) begin
            cur_beats <= pkt_size;
            idle      <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_count <= '0;
        end else if (accepted) begin
            beat_count <= beat_count + STAT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (pkt_done) begin
            pkt_count <= pkt_count + STAT_WIDTH'(1);
        end
    end

    // largest finished packet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            max_pkt <= '0;
        end else if (pkt_done && (pkt_size > max_pkt)) begin
            max_pkt <= pkt_size;
        end
    end

    always_comb begin
        stats.pkt_count    = stat_cnt_t'(pkt_count);
        stats.beat_count   = stat_cnt_t'(beat_count);
        stats.max_pkt_size = stat_cnt_t'(max_pkt);
        stats.idle         = idle;
    end

    max_pkt_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        max_pkt >= $past(max_pkt)
    ) else $error("largest packet size decreased");

endmodule

/* logic/cmac_recv_monitor.sv */
`timescale 1ns/1ps

module cmac_recv_monitor
    import cmac_axis_pkg::*, cmac_stat_pkg::*;
#(
    parameter int STAT_WIDTH = STAT_WIDTH_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  axis_beat_t               beat,
    input  logic [BAD_FCS_WIDTH-1:0] bad_fcs,
    output rx_stats_t                stats
);

    pkt_stats_t            pkt_stats;
    logic [STAT_WIDTH-1:0] lost_count;
    logic [STAT_WIDTH-1:0] bad_fcs_count;

    cmac_pkt_tracker #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_tracker (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .stats (pkt_stats)
    );

    // a beat refused by the sink is gone since the MAC cannot stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lost_count <= '0;
        end else if (beat_lost(beat)) begin
            lost_count <= lost_count + STAT_WIDTH'(1);
        end
    end

    // strobe carries a count as several bad frames may end in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bad_fcs_count <= '0;
        end else begin
            bad_fcs_count <= bad_fcs_count + STAT_WIDTH'(bad_fcs);
        end
    end

    always_comb begin
        stats.pkt             = pkt_stats;
        stats.lost_beat_count = stat_cnt_t'(lost_count);
        stats.bad_fcs_count   = stat_cnt_t'(bad_fcs_count);
    end

    // sink is always ready while frame data flows, so a ready without valid
    // in the middle of a packet points at a broken sink handshake
    rx_ready_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!pkt_stats.idle && !beat.valid) |-> !beat.ready
    ) else $error("rx ready high without valid inside a packet");

endmodule

/* logic/cmac_send_monitor.sv */
`timescale 1ns/1ps

module cmac_send_monitor
    import cmac_axis_pkg::*, cmac_stat_pkg::*;
#(
    parameter int STAT_WIDTH = STAT_WIDTH_DEFAULT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  axis_beat_t beat,
    input  logic       ovfout,
    input  logic       unfout,
    output tx_stats_t  stats
);

    pkt_stats_t            pkt_stats;
    logic [STAT_WIDTH-1:0] ovf_count;
    logic [STAT_WIDTH-1:0] unf_count;

    // ready gaps on tx are plain back-pressure and lose nothing
    cmac_pkt_tracker #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_tracker (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .stats (pkt_stats)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_count <= '0;
        end else if (ovfout) begin
            ovf_count <= ovf_count + STAT_WIDTH'(1); // one per strobe cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unf_count <= '0;
        end else if (unfout) begin
            unf_count <= unf_count + STAT_WIDTH'(1);
        end
    end

    always_comb begin
        stats.pkt       = pkt_stats;
        stats.ovf_count = stat_cnt_t'(ovf_count);
        stats.unf_count = stat_cnt_t'(unf_count);
    end

    // MAC tx fifo cannot run over and dry in the same cycle
    tx_ovf_unf_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ovfout && unfout)
    ) else $error("tx overflow and underflow in the same cycle");

endmodule

/* logic/cmac_axis_monitor.sv */
`timescale 1ns/1ps

module cmac_axis_monitor
    import cmac_axis_pkg::*, cmac_stat_pkg::*;
#(
    parameter int STAT_WIDTH = STAT_WIDTH_DEFAULT
) (
    input  logic                     gt_txusrclk2,
    input  logic                     rst_n,

    // MAC to DMA stream and MAC status
    input  axis_beat_t               rx_beat,
    input  logic [BAD_FCS_WIDTH-1:0] rx_bad_fcs,

    // DMA to MAC stream and MAC status
    input  axis_beat_t               tx_beat,
    input  logic                     tx_ovfout,
    input  logic                     tx_unfout,

    output rx_stats_t                rx_stats,
    output tx_stats_t                tx_stats
);

    // both directions share the MAC user clock and one reset
    cmac_recv_monitor #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_recv_monitor (
        .clk     (gt_txusrclk2),
        .rst_n   (rst_n),
        .beat    (rx_beat),
        .bad_fcs (rx_bad_fcs),
        .stats   (rx_stats)
    );

    cmac_send_monitor #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_send_monitor (
        .clk    (gt_txusrclk2),
        .rst_n  (rst_n),
        .beat   (tx_beat),
        .ovfout (tx_ovfout),
        .unfout (tx_unfout),
        .stats  (tx_stats)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on the edge that ends the last reset cycle
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verif/cmac_monitor_tb.sv */
`timescale 1ns/1ps

module cmac_monitor_tb
    import cmac_axis_pkg::*, cmac_stat_pkg::*;
;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 3;
    localparam int MAX_LEN       = 16;
    localparam int RX_PKTS       = 8;
    localparam int GAP_PKTS      = 6;
    localparam int FCS_CYCLES    = 16;
    localparam int TX_PKTS       = 6;
    localparam int STROBE_CYCLES = 12;

    // gap tests can add one stall cycle before every beat
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + RX_PKTS * MAX_LEN
                                + GAP_PKTS * 2 * MAX_LEN + FCS_CYCLES
                                + TX_PKTS * 2 * MAX_LEN + STROBE_CYCLES;
    localparam int TIMEOUT_NS   = (2 * TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic                     clk;
    logic                     rst_n;
    axis_beat_t               rx_beat;
    logic [BAD_FCS_WIDTH-1:0] rx_bad_fcs;
    axis_beat_t               tx_beat;
    logic                     tx_ovfout;
    logic                     tx_unfout;
    rx_stats_t                rx_stats;
    tx_stats_t                tx_stats;

    // reference model state
    rx_stats_t   exp_rx;
    tx_stats_t   exp_tx;
    int          rx_cur;
    int          tx_cur;
    logic [31:0] lcg_state = 32'h0c48_f8d6;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cmac_axis_monitor #(
        .STAT_WIDTH (STAT_WIDTH_DEFAULT)
    ) uut (
        .gt_txusrclk2 (clk),
        .rst_n        (rst_n),
        .rx_beat      (rx_beat),
        .rx_bad_fcs   (rx_bad_fcs),
        .tx_beat      (tx_beat),
        .tx_ovfout    (tx_ovfout),
        .tx_unfout    (tx_unfout),
        .rx_stats     (rx_stats),
        .tx_stats     (tx_stats)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_len();
        return int'((next_rand() >> 16) % MAX_LEN) + 1;
    endfunction

    function automatic axis_beat_t make_beat(input logic valid, input logic ready,
                                             input logic last);
        axis_beat_t b;
        b.valid = valid;
        b.ready = ready;
        b.last  = last;
        return b;
    endfunction

    task automatic check_value(input string name, input stat_cnt_t expected,
                               input stat_cnt_t actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_reports();
        check_value("rx_stats.pkt.pkt_count", exp_rx.pkt.pkt_count, rx_stats.pkt.pkt_count);
        check_value("rx_stats.pkt.beat_count", exp_rx.pkt.beat_count, rx_stats.pkt.beat_count);
        check_value("rx_stats.pkt.max_pkt_size", exp_rx.pkt.max_pkt_size,
                    rx_stats.pkt.max_pkt_size);
        check_value("rx_stats.pkt.idle", exp_rx.pkt.idle, rx_stats.pkt.idle);
        check_value("rx_stats.lost_beat_count", exp_rx.lost_beat_count,
                    rx_stats.lost_beat_count);
        check_value("rx_stats.bad_fcs_count", exp_rx.bad_fcs_count, rx_stats.bad_fcs_count);
        check_value("tx_stats.pkt.pkt_count", exp_tx.pkt.pkt_count, tx_stats.pkt.pkt_count);
        check_value("tx_stats.pkt.beat_count", exp_tx.pkt.beat_count, tx_stats.pkt.beat_count);
        check_value("tx_stats.pkt.max_pkt_size", exp_tx.pkt.max_pkt_size,
                    tx_stats.pkt.max_pkt_size);
        check_value("tx_stats.pkt.idle", exp_tx.pkt.idle, tx_stats.pkt.idle);
        check_value("tx_stats.ovf_count", exp_tx.ovf_count, tx_stats.ovf_count);
        check_value("tx_stats.unf_count", exp_tx.unf_count, tx_stats.unf_count);
    endtask

    // a beat counts on valid and ready and an accepted last beat closes the packet
    task automatic model_beat(input axis_beat_t beat, inout pkt_stats_t exp, inout int cur);
        if (beat.valid && beat.ready) begin
            exp.beat_count += 1;
            cur += 1;
            if (beat.last) begin
                exp.pkt_count += 1;
                if (stat_cnt_t'(cur) > exp.max_pkt_size) begin
                    exp.max_pkt_size = stat_cnt_t'(cur);
                end
                cur = 0;
            end
        end
        exp.idle = (cur == 0);
    endtask

    // one clock of stimulus and the model update for what the edge sampled
    task automatic drive_cycle(input axis_beat_t rx, input logic [BAD_FCS_WIDTH-1:0] fcs,
                               input axis_beat_t tx, input logic ovf, input logic unf);
        rx_beat    = rx;
        rx_bad_fcs = fcs;
        tx_beat    = tx;
        tx_ovfout  = ovf;
        tx_unfout  = unf;
        @(posedge clk);
        #DRIVE_DELAY;
        model_beat(rx, exp_rx.pkt, rx_cur);
        if (rx.valid && !rx.ready) begin
            exp_rx.lost_beat_count += 1;
        end
        exp_rx.bad_fcs_count += stat_cnt_t'(fcs);
        model_beat(tx, exp_tx.pkt, tx_cur);
        if (ovf) begin
            exp_tx.ovf_count += 1;
        end
        if (unf) begin
            exp_tx.unf_count += 1;
        end
    endtask

    // valid stays high inside a packet and stalls only drop ready
    task automatic send_rx_packet(input int len, input logic with_gaps);
        for (int i = 0; i < len; i++) begin
            if (with_gaps && ((next_rand() >> 16) % 4 == 0)) begin
                drive_cycle(make_beat(1'b1, 1'b0, 1'b0), '0, '0, 1'b0, 1'b0);
                check_value("rx_stats.lost_beat_count", exp_rx.lost_beat_count,
                            rx_stats.lost_beat_count);
            end
            drive_cycle(make_beat(1'b1, 1'b1, i == len - 1), '0, '0, 1'b0, 1'b0);
            check_value("rx_stats.pkt.idle", exp_rx.pkt.idle, rx_stats.pkt.idle);
        end
    endtask

    task automatic test_reset();
        check_reports();
    endtask

    task automatic test_rx_packets();
        repeat (RX_PKTS) send_rx_packet(rand_len(), 1'b0);
        check_reports();
    endtask

    task automatic test_rx_lost_beats();
        repeat (GAP_PKTS) send_rx_packet(rand_len(), 1'b1);
        check_reports();
    endtask

    task automatic test_rx_bad_fcs();
        logic [BAD_FCS_WIDTH-1:0] fcs;
        for (int i = 0; i < FCS_CYCLES; i++) begin
            fcs = (i < 8) ? BAD_FCS_WIDTH'(i) : BAD_FCS_WIDTH'(next_rand() >> 8);
            drive_cycle('0, fcs, '0, 1'b0, 1'b0);
        end
        check_reports();
    endtask

    task automatic test_tx();
        int          len;
        logic [31:0] sel;
        for (int p = 0; p < TX_PKTS; p++) begin
            len = rand_len();
            for (int i = 0; i < len; i++) begin
                if (next_rand() % 3 == 0) begin
                    drive_cycle('0, '0, make_beat(1'b1, 1'b0, 1'b0), 1'b0, 1'b0);
                end
                drive_cycle('0, '0, make_beat(1'b1, 1'b1, i == len - 1), 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < STROBE_CYCLES; i++) begin
            sel = next_rand() % 3; // 0 none, 1 overflow, 2 underflow
            drive_cycle('0, '0, '0, sel == 1, sel == 2);
        end
        check_reports();
    endtask

    initial begin
        #TIMEOUT_NS;
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rx_beat    = '0;
        rx_bad_fcs = '0;
        tx_beat    = '0;
        tx_ovfout  = 1'b0;
        tx_unfout  = 1'b0;
        exp_rx     = '0;
        exp_tx     = '0;
        exp_rx.pkt.idle = 1'b1;
        exp_tx.pkt.idle = 1'b1;
        rx_cur     = 0;
        tx_cur     = 0;

        wait (rst_n === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;

        test_reset();
        test_rx_packets();
        test_rx_lost_beats();
        test_rx_bad_fcs();
        test_tx();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
logic/cmac_axis_pkg.sv
logic/cmac_stat_pkg.sv
logic/cmac_pkt_tracker.sv
logic/cmac_recv_monitor.sv
logic/cmac_send_monitor.sv
logic/cmac_axis_monitor.sv
verif/tb_clock_gen.sv
verif/cmac_monitor_tb.sv
